// ==== src.f ====
+incdir+design
+incdir+testbench
design/axi_pkg.sv
design/zstd_pkg.sv
design/mem_read_arbiter.sv
design/csr_regfile.sv
design/zstd_dec_wrapper.sv
testbench/tb_zstd_dec_wrapper.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_zstd_dec_wrapper
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Memory contents seen by the read clients
function automatic axi_data_t mem_word(axi_addr_t addr, int beat);
  return (axi_data_t'(addr) + axi_data_t'(beat)) ^ 32'h5c3a_9e17;
endfunction

// First requester after the last grant, in cyclic order
function automatic int rr_pick(int last, logic [3:0] mask);
  int c;
  for (int k = 1; k <= 4; k++) begin
    c = (last + k) % 4;
    if (mask[c]) return c;
  end
  return last;
endfunction

// Bytes with a strobe take the new data
function automatic axi_data_t merge_ref(axi_data_t old, axi_data_t data, axi_strb_t strb);
  axi_data_t mask;
  mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  return (old & ~mask) | (data & mask);
endfunction

task automatic stop_run();
  $display("Verification failed");
  $fatal(1);
endtask

task automatic fail_with_note(string what);
  $display("%s at time %0t", what, $time);
  stop_run();
endtask

task automatic check_val(string name, logic [127:0] exp, logic [127:0] act);
  if (exp !== act) begin
    $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
    stop_run();
  end
endtask

`endif

// ==== testbench/tb_zstd_dec_wrapper.sv ====
`include "zstd_defines.svh"

module tb_zstd_dec_wrapper
  import axi_pkg::*;
  import zstd_pkg::*;
();

  localparam int TMO = 200;

  logic clk;
  logic rst_n;
  axi_ar_t client_ar [`MEM_CLIENT_COUNT];
  logic [3:0] client_ar_valid, client_ar_ready, client_r_valid, client_r_ready;
  axi_r_t client_r [`MEM_CLIENT_COUNT];
  axi_aw_t seq_aw, mem_aw, csr_aw;
  axi_w_t seq_w, mem_w, csr_w;
  axi_b_t seq_b, csr_b;
  axi_ar_t mem_ar, csr_ar;
  axi_mem_r_t mem_r;
  axi_mem_b_t mem_b;
  axi_r_t csr_r;
  axi_data_t status;
  csr_regs_t regs;
  logic seq_aw_valid, seq_aw_ready, seq_w_valid, seq_w_ready, seq_b_valid, seq_b_ready;
  logic mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
  logic mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready, mem_b_valid, mem_b_ready;
  logic csr_aw_valid, csr_aw_ready, csr_w_valid, csr_w_ready, csr_b_valid, csr_b_ready;
  logic csr_ar_valid, csr_ar_ready, csr_r_valid, csr_r_ready;

  int seed = 32'h650b;
  int mem_seed = 32'h650b + 1;
  int rdy_seed = 32'h650b + 2;
  logic stall_en = 1'b0;
  axi_r_t exp_q [4][$];
  axi_data_t csr_model [4];
  int last_grant = 3;
  logic [3:0] hold_v = '0;
  axi_r_t hold_r [4];

  `include "tb_checks.svh"

  zstd_dec_wrapper dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : ready_driver
    client_r_ready = '1;
    forever begin
      @(posedge clk);
      #1 client_r_ready = stall_en ? 4'($random(rdy_seed)) : 4'hf;
    end
  end

  initial begin : mem_model
    axi_ar_t req;
    int d;
    int n;
    mem_ar_ready = 1'b0;
    mem_r_valid = 1'b0;
    mem_r = '0;
    forever begin
      @(posedge clk);
      if (mem_ar_valid === 1'b1) begin
        #1 mem_ar_ready = 1'b1;
        req = mem_ar;
        @(posedge clk);
        #1 mem_ar_ready = 1'b0;
        d = int'($unsigned($random(mem_seed)) % 4);
        repeat (d) begin
          @(posedge clk);
          #1;
        end
        for (int b = 0; b <= int'(req.len); b++) begin
          mem_r = '{id: req.id, data: mem_word(req.addr, b), resp: 2'd0,
                    last: b == int'(req.len)};
          mem_r_valid = 1'b1;
          n = 0;
          do begin
            @(posedge clk);
            n++;
            if (n > TMO) fail_with_note("memory read beat never accepted");
          end while (!mem_r_ready);
          #1;
        end
        mem_r_valid = 1'b0;
      end
    end
  end

  // Compares every read beat, grant order and stalled payloads
  always @(posedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < 4; i++) begin
        if (hold_v[i]) begin
          check_val("client_r_valid", 128'(1'b1), 128'(client_r_valid[i]));
          check_val("client_r stalled", 128'(hold_r[i]), 128'(client_r[i]));
        end
        if (client_r_valid[i] && client_r_ready[i]) begin
          if (exp_q[i].size() == 0) fail_with_note("read beat reached a client that expected none");
          check_val("client_r", 128'(exp_q[i].pop_front()), 128'(client_r[i]));
        end
        if (client_ar_valid[i] && client_ar_ready[i]) begin
          check_val("grant", 128'(rr_pick(last_grant, client_ar_valid)), 128'(i));
          last_grant = i;
        end
        hold_v[i] = client_r_valid[i] && !client_r_ready[i];
        hold_r[i] = client_r[i];
      end
    end
  end

  task automatic csr_write(axi_addr_t a, axi_data_t d, axi_strb_t s, axi_id_t id);
    int n;
    int idx;
    idx = int'(a >> 2);
    csr_aw = '{id: id, addr: a, len: 8'd0, size: 3'd2, burst: 2'd1};
    csr_w = '{data: d, strb: s, last: 1'b1};
    csr_aw_valid = 1'b1;
    csr_w_valid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TMO) fail_with_note("CSR write never accepted");
    end while (!csr_aw_ready);
    check_val("csr_w_ready", 128'(1'b1), 128'(csr_w_ready));
    #1 csr_aw_valid = 1'b0;
    csr_w_valid = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TMO) fail_with_note("CSR write response never came");
    end while (!csr_b_valid);
    check_val("csr_b.id", 128'(id), 128'(csr_b.id));
    check_val("csr_b.resp", 128'(idx < 4 ? 0 : 2), 128'(csr_b.resp));
    if (idx < 4 && idx != 1) csr_model[idx] = merge_ref(csr_model[idx], d, s);
    #1;
  endtask

  task automatic csr_read(axi_addr_t a, axi_id_t id);
    int n;
    int idx;
    axi_data_t exp_d;
    idx = int'(a >> 2);
    if (idx >= 4) exp_d = '0;
    else if (idx == 1) exp_d = status;
    else exp_d = csr_model[idx];
    csr_ar = '{id: id, addr: a, len: 8'd0, size: 3'd2, burst: 2'd1};
    csr_ar_valid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TMO) fail_with_note("CSR read never accepted");
    end while (!csr_ar_ready);
    #1 csr_ar_valid = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TMO) fail_with_note("CSR read data never came");
    end while (!csr_r_valid);
    check_val("csr_r.id", 128'(id), 128'(csr_r.id));
    check_val("csr_r.data", 128'(exp_d), 128'(csr_r.data));
    check_val("csr_r.resp", 128'(idx < 4 ? 0 : 2), 128'(csr_r.resp));
    #1;
  endtask

  task automatic issue_batch(logic [3:0] mask);
    int n;
    logic [3:0] pend;
    axi_ar_t req;
    axi_r_t beat;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        req = '{id: axi_id_t'($random(seed)), addr: axi_addr_t'($random(seed)) & 16'hfffc,
                len: axi_len_t'($unsigned($random(seed)) % 4), size: 3'd2, burst: 2'd1};
        client_ar[i] = req;
        for (int b = 0; b <= int'(req.len); b++) begin
          beat = '{id: req.id, data: mem_word(req.addr, b), resp: 3'd0,
                   last: b == int'(req.len)};
          exp_q[i].push_back(beat);
        end
      end
    end
    client_ar_valid = mask;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TMO) fail_with_note("client read request never granted");
      pend = client_ar_valid & ~client_ar_ready;
      #1 client_ar_valid = pend;
    end while (pend != 0);
  endtask

  initial begin : stimulus
    int n;
    rst_n = 1'b0;
    for (int i = 0; i < 4; i++) client_ar[i] = '0;
    client_ar_valid = '0;
    seq_aw = '0;
    seq_aw_valid = 1'b0;
    seq_w = '0;
    seq_w_valid = 1'b0;
    seq_b_ready = 1'b1;
    mem_aw_ready = 1'b0;
    mem_w_ready = 1'b0;
    mem_b = '0;
    mem_b_valid = 1'b0;
    csr_aw = '0;
    csr_aw_valid = 1'b0;
    csr_w = '0;
    csr_w_valid = 1'b0;
    csr_b_ready = 1'b1;
    csr_ar = '0;
    csr_ar_valid = 1'b0;
    csr_r_ready = 1'b1;
    status = 32'h00c0_ffee;
    for (int i = 0; i < 4; i++) csr_model[i] = '0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int i = 0; i < 4; i++) begin
      csr_write(axi_addr_t'(i * 4), axi_data_t'($random(seed)), axi_strb_t'($random(seed)),
                axi_id_t'(i + 3));
    end
    for (int i = 0; i < 4; i++) csr_read(axi_addr_t'(i * 4), axi_id_t'(i + 8));
    check_val("regs", 128'({csr_model[3], csr_model[2], status, csr_model[0]}), 128'(regs));
    // Out of range accesses
    csr_write(16'h0010, 32'hdead_beef, 4'hf, 4'h1);
    csr_write(16'h0044, 32'h1234_5678, 4'hf, 4'h2);
    csr_read(16'h0010, 4'h3);
    check_val("regs", 128'({csr_model[3], csr_model[2], status, csr_model[0]}), 128'(regs));

    // Write path straight through
    seq_aw = '{id: 4'h9, addr: 16'h1230, len: 8'd0, size: 3'd2, burst: 2'd1};
    seq_w = '{data: 32'hcafe_f00d, strb: 4'h5, last: 1'b1};
    seq_aw_valid = 1'b1;
    seq_w_valid = 1'b1;
    mem_aw_ready = 1'b1;
    mem_w_ready = 1'b1;
    mem_b = '{id: 4'h9, resp: 2'd1};
    mem_b_valid = 1'b1;
    @(posedge clk);
    check_val("mem_aw", 128'(seq_aw), 128'(mem_aw));
    check_val("mem_w", 128'(seq_w), 128'(mem_w));
    check_val("mem_valids", 128'(2'b11), 128'({mem_aw_valid, mem_w_valid}));
    check_val("seq_readys", 128'(3'b111), 128'({seq_aw_ready, seq_w_ready, mem_b_ready}));
    check_val("seq_b", 128'(7'h49), 128'(seq_b));
    check_val("seq_b_valid", 128'(1'b1), 128'(seq_b_valid));
    #1 seq_aw_valid = 1'b0;
    seq_w_valid = 1'b0;
    mem_b_valid = 1'b0;
    // Idle channels with mixed readies
    mem_aw_ready = 1'b0;
    mem_w_ready = 1'b1;
    seq_b_ready = 1'b0;
    @(posedge clk);
    check_val("mem_valids", 128'(2'b00), 128'({mem_aw_valid, mem_w_valid}));
    check_val("seq_readys", 128'(3'b010), 128'({seq_aw_ready, seq_w_ready, mem_b_ready}));
    check_val("seq_b_valid", 128'(1'b0), 128'(seq_b_valid));
    #1 seq_b_ready = 1'b1;

    for (int k = 0; k < 4; k++) issue_batch(4'hf);
    stall_en = 1'b1;
    for (int k = 0; k < 12; k++) issue_batch(4'($random(seed)) | 4'h1);
    issue_batch(4'hf);

    n = 0;
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
      @(posedge clk);
      n++;
      if (n > TMO) fail_with_note("read beats still missing at the end");
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== design/zstd_dec_wrapper.sv ====
`include "zstd_defines.svh"

module zstd_dec_wrapper
  import axi_pkg::*;
  import zstd_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,

  // Decoder read clients
  input  axi_ar_t                      client_ar [`MEM_CLIENT_COUNT],
  input  logic [`MEM_CLIENT_COUNT-1:0] client_ar_valid,
  output logic [`MEM_CLIENT_COUNT-1:0] client_ar_ready,
  output axi_r_t                       client_r [`MEM_CLIENT_COUNT],
  output logic [`MEM_CLIENT_COUNT-1:0] client_r_valid,
  input  logic [`MEM_CLIENT_COUNT-1:0] client_r_ready,

  // Sequence executor writes
  input  axi_aw_t                      seq_aw,
  input  logic                         seq_aw_valid,
  output logic                         seq_aw_ready,
  input  axi_w_t                       seq_w,
  input  logic                         seq_w_valid,
  output logic                         seq_w_ready,
  output axi_b_t                       seq_b,
  output logic                         seq_b_valid,
  input  logic                         seq_b_ready,

  // Memory master
  output axi_ar_t                      mem_ar,
  output logic                         mem_ar_valid,
  input  logic                         mem_ar_ready,
  input  axi_mem_r_t                   mem_r,
  input  logic                         mem_r_valid,
  output logic                         mem_r_ready,
  output axi_aw_t                      mem_aw,
  output logic                         mem_aw_valid,
  input  logic                         mem_aw_ready,
  output axi_w_t                       mem_w,
  output logic                         mem_w_valid,
  input  logic                         mem_w_ready,
  input  axi_mem_b_t                   mem_b,
  input  logic                         mem_b_valid,
  output logic                         mem_b_ready,

  // CSR slave
  input  axi_aw_t                      csr_aw,
  input  logic                         csr_aw_valid,
  output logic                         csr_aw_ready,
  input  axi_w_t                       csr_w,
  input  logic                         csr_w_valid,
  output logic                         csr_w_ready,
  output axi_b_t                       csr_b,
  output logic                         csr_b_valid,
  input  logic                         csr_b_ready,
  input  axi_ar_t                      csr_ar,
  input  logic                         csr_ar_valid,
  output logic                         csr_ar_ready,
  output axi_r_t                       csr_r,
  output logic                         csr_r_valid,
  input  logic                         csr_r_ready,
  input  axi_data_t                    status,
  output csr_regs_t                    regs
);

  mem_read_arbiter u_read_arb (
    .clk, .rst_n,
    .client_ar, .client_ar_valid, .client_ar_ready,
    .client_r, .client_r_valid, .client_r_ready,
    .mem_ar, .mem_ar_valid, .mem_ar_ready,
    .mem_r, .mem_r_valid, .mem_r_ready
  );

  csr_regfile u_csr (
    .clk, .rst_n,
    .csr_aw, .csr_aw_valid, .csr_aw_ready,
    .csr_w, .csr_w_valid, .csr_w_ready,
    .csr_b, .csr_b_valid, .csr_b_ready,
    .csr_ar, .csr_ar_valid, .csr_ar_ready,
    .csr_r, .csr_r_valid, .csr_r_ready,
    .status, .regs
  );

  // Write path has no other master
  assign mem_aw       = seq_aw;
  assign mem_aw_valid = seq_aw_valid;
  assign seq_aw_ready = mem_aw_ready;
  assign mem_w        = seq_w;
  assign mem_w_valid  = seq_w_valid;
  assign seq_w_ready  = mem_w_ready;
  assign seq_b        = '{id: mem_b.id, resp: widen_resp(mem_b.resp)};
  assign seq_b_valid  = mem_b_valid;
  assign mem_b_ready  = seq_b_ready;

endmodule

// ==== design/csr_regfile.sv ====
`include "zstd_defines.svh"

module csr_regfile
  import axi_pkg::*;
  import zstd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  axi_aw_t   csr_aw,
  input  logic      csr_aw_valid,
  output logic      csr_aw_ready,
  input  axi_w_t    csr_w,
  input  logic      csr_w_valid,
  output logic      csr_w_ready,
  output axi_b_t    csr_b,
  output logic      csr_b_valid,
  input  logic      csr_b_ready,
  input  axi_ar_t   csr_ar,
  input  logic      csr_ar_valid,
  output logic      csr_ar_ready,
  output axi_r_t    csr_r,
  output logic      csr_r_valid,
  input  logic      csr_r_ready,
  input  axi_data_t status,
  output csr_regs_t regs
);

  localparam xls_resp_t RESP_OKAY   = 3'd0;
  localparam xls_resp_t RESP_SLVERR = 3'd2;

  axi_data_t ctrl_q;
  axi_data_t input_buf_q;
  axi_data_t output_buf_q;
  axi_data_t rd_data;
  logic      wr_fire;
  logic      rd_fire;

  function automatic logic addr_ok(axi_addr_t addr);
    return (addr >> 2) < `CSR_REG_COUNT;
  endfunction

  function automatic csr_reg_e reg_index(axi_addr_t addr);
    return csr_reg_e'(addr[$bits(csr_reg_e)+1:2]);
  endfunction

  function automatic axi_data_t merge(axi_data_t old, axi_data_t data, axi_strb_t strb);
    axi_data_t res;
    res = old;
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Address and data are taken together
  assign csr_aw_ready = !csr_b_valid && csr_w_valid;
  assign csr_w_ready  = !csr_b_valid && csr_aw_valid;
  assign wr_fire      = !csr_b_valid && csr_aw_valid && csr_w_valid;
  assign csr_ar_ready = !csr_r_valid;
  assign rd_fire      = csr_ar_valid && csr_ar_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_q       <= '0;
      input_buf_q  <= '0;
      output_buf_q <= '0;
    end else if (wr_fire && addr_ok(csr_aw.addr)) begin
      case (reg_index(csr_aw.addr))
        CSR_CTRL:       ctrl_q       <= merge(ctrl_q, csr_w.data, csr_w.strb);
        CSR_INPUT_BUF:  input_buf_q  <= merge(input_buf_q, csr_w.data, csr_w.strb);
        CSR_OUTPUT_BUF: output_buf_q <= merge(output_buf_q, csr_w.data, csr_w.strb);
        // Status is read-only
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_index(csr_ar.addr))
      CSR_CTRL:       rd_data = ctrl_q;
      CSR_STATUS:     rd_data = status;
      CSR_INPUT_BUF:  rd_data = input_buf_q;
      default:        rd_data = output_buf_q;
    endcase
    if (!addr_ok(csr_ar.addr)) begin
      rd_data = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_b_valid <= 1'b0;
      csr_r_valid <= 1'b0;
    end else begin
      if (wr_fire) begin
        csr_b_valid <= 1'b1;
      end else if (csr_b_ready) begin
        csr_b_valid <= 1'b0;
      end
      if (rd_fire) begin
        csr_r_valid <= 1'b1;
      end else if (csr_r_ready) begin
        csr_r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      csr_b <= '{id: csr_aw.id, resp: addr_ok(csr_aw.addr) ? RESP_OKAY : RESP_SLVERR};
    end
    if (rd_fire) begin
      csr_r <= '{id: csr_ar.id, data: rd_data,
                 resp: addr_ok(csr_ar.addr) ? RESP_OKAY : RESP_SLVERR, last: 1'b1};
    end
  end

  assign regs = '{output_buf: output_buf_q, input_buf: input_buf_q, status: status,
                  ctrl: ctrl_q};

  // Single beat writes only
  wr_single_beat_a: assert property (@(posedge clk) disable iff (!rst_n)
    wr_fire |-> csr_w.last);

endmodule

// ==== design/mem_read_arbiter.sv ====
`include "zstd_defines.svh"

module mem_read_arbiter
  import axi_pkg::*;
  import zstd_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  axi_ar_t                      client_ar [`MEM_CLIENT_COUNT],
  input  logic [`MEM_CLIENT_COUNT-1:0] client_ar_valid,
  output logic [`MEM_CLIENT_COUNT-1:0] client_ar_ready,
  output axi_r_t                       client_r [`MEM_CLIENT_COUNT],
  output logic [`MEM_CLIENT_COUNT-1:0] client_r_valid,
  input  logic [`MEM_CLIENT_COUNT-1:0] client_r_ready,
  output axi_ar_t                      mem_ar,
  output logic                         mem_ar_valid,
  input  logic                         mem_ar_ready,
  input  axi_mem_r_t                   mem_r,
  input  logic                         mem_r_valid,
  output logic                         mem_r_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_e;

  state_e      state_q;
  axi_ar_t     ar_q;
  mem_client_e grant_q;
  mem_client_e last_q;
  mem_client_e pick_idx;
  logic        pick_found;
  logic        burst_done;
  axi_r_t      r_beat;

  // Round robin search starting after the last grant
  always_comb begin
    mem_client_e cand;
    pick_found = 1'b0;
    pick_idx   = last_q;
    for (int i = 1; i <= `MEM_CLIENT_COUNT; i++) begin
      cand = mem_client_e'((int'(last_q) + i) % `MEM_CLIENT_COUNT);
      if (!pick_found && client_ar_valid[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  assign burst_done = (state_q == ST_DATA) && mem_r_valid && mem_r_ready && mem_r.last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      grant_q <= FH;
      // Makes the first search start at FH
      last_q  <= RLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pick_found) begin
            state_q <= ST_ADDR;
            grant_q <= pick_idx;
          end
        end
        ST_ADDR: begin
          if (mem_ar_ready) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (burst_done) begin
            state_q <= ST_IDLE;
            last_q  <= grant_q;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && pick_found) begin
      ar_q <= client_ar[pick_idx];
    end
  end

  assign mem_ar       = ar_q;
  assign mem_ar_valid = (state_q == ST_ADDR);
  assign mem_r_ready  = (state_q == ST_DATA) && client_r_ready[grant_q];

  assign r_beat = '{id: mem_r.id, data: mem_r.data, resp: widen_resp(mem_r.resp),
                    last: mem_r.last};

  // Payload goes to every client, valid only to the winner
  always_comb begin
    for (int i = 0; i < `MEM_CLIENT_COUNT; i++) begin
      client_r[i]        = r_beat;
      client_r_valid[i]  = (state_q == ST_DATA) && (int'(grant_q) == i) && mem_r_valid;
      client_ar_ready[i] = (state_q == ST_ADDR) && (int'(grant_q) == i) && mem_ar_ready;
    end
  end

  ar_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar));

  r_single_client_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(client_r_valid));

endmodule

// ==== design/zstd_pkg.sv ====
`include "zstd_defines.svh"

package zstd_pkg;
  import axi_pkg::*;

  // Read clients in arbitration order
  typedef enum logic [$clog2(`MEM_CLIENT_COUNT)-1:0] {
    FH  = 0,
    BH  = 1,
    RAW = 2,
    RLE = 3
  } mem_client_e;

  // Word index of each CSR
  typedef enum logic [$clog2(`CSR_REG_COUNT)-1:0] {
    CSR_CTRL       = 0,
    CSR_STATUS     = 1,
    CSR_INPUT_BUF  = 2,
    CSR_OUTPUT_BUF = 3
  } csr_reg_e;

  // Register contents as seen by the decoder core
  typedef struct packed {
    axi_data_t output_buf;
    axi_data_t input_buf;
    axi_data_t status;
    axi_data_t ctrl;
  } csr_regs_t;

endpackage

// ==== design/axi_pkg.sv ====
`include "zstd_defines.svh"

package axi_pkg;

  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;
  typedef logic [`AXI_ID_W-1:0]   axi_id_t;
  typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
  // Beats minus one
  typedef logic [7:0]             axi_len_t;
  typedef logic [2:0]             axi_size_t;
  typedef logic [1:0]             axi_burst_t;
  // Memory side response code
  typedef logic [1:0]             axi_resp_t;
  // Client side response code, top bit unused
  typedef logic [2:0]             xls_resp_t;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ar_t;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_aw_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    xls_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_mem_r_t;

  typedef struct packed {
    axi_id_t   id;
    xls_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_mem_b_t;

  // Memory code toward a client
  function automatic xls_resp_t widen_resp(axi_resp_t resp);
    return {1'b0, resp};
  endfunction

endpackage

// ==== design/zstd_defines.svh ====
`ifndef ZSTD_DEFINES_SVH
`define ZSTD_DEFINES_SVH

// AXI bus widths shared by the memory and CSR ports
`define AXI_DATA_W 32

`define AXI_ADDR_W 16

`define AXI_ID_W 4

// One strobe bit per data byte
`define AXI_STRB_W 4

// Decoder clients that read from memory
`define MEM_CLIENT_COUNT 4

// Word registers behind the CSR port
`define CSR_REG_COUNT 4

`endif
